// File: test/l2_vectors.txt
// test op unit strand way address mask data exp_status exp_update exp_way exp_data
// Data words fill the low bytes of the 512-bit line, the upper bytes are zero
01 1 0 0 0 0000010 ffffffffffffffff 1111111111111111 1 0 0 1111111111111111
01 1 0 0 0 0000010 0f0000000000005a aabbccddeeff0011 1 0 0 11bb11ddee110011
01 0 0 0 2 0000010 0 0 1 0 2 11bb11ddee110011
02 1 0 1 0 0000020 ffffffffffffffff 2222222222222222 1 0 0 2222222222222222
02 4 0 1 1 0000020 0 0 1 0 1 2222222222222222
02 5 0 1 0 0000020 000000000000000f 9999999999999999 1 0 0 2222222299999999
02 0 0 1 0 0000020 0 0 1 0 0 2222222299999999
03 1 0 0 0 0000030 ffffffffffffffff 3333333333333333 1 0 0 3333333333333333
03 4 0 0 0 0000030 0 0 1 0 0 3333333333333333
03 1 0 2 0 0000030 ffffffffffffffff 4444444444444444 1 0 0 4444444444444444
03 5 0 0 0 0000030 ffffffffffffffff 5555555555555555 0 0 0 5555555555555555
03 0 0 0 0 0000030 0 0 1 0 0 4444444444444444
04 1 0 0 0 0000045 ffffffffffffffff 6666666666666666 1 0 0 6666666666666666
04 0 1 0 3 0000045 0 0 1 0 3 6666666666666666
04 1 1 0 0 0000045 0000000000000003 0000000000007777 1 1 3 6666666666667777
04 1 0 0 0 0000065 ffffffffffffffff 8888888888888888 1 0 0 8888888888888888
05 1 0 0 0 0000050 ffffffffffffffff aaaaaaaaaaaaaaaa 1 0 0 aaaaaaaaaaaaaaaa
05 1 2 1 0 0000051 ffffffffffffffff bbbbbbbbbbbbbbbb 1 0 0 bbbbbbbbbbbbbbbb
05 0 3 3 1 0000050 0 0 1 0 1 aaaaaaaaaaaaaaaa
05 0 0 2 2 0000051 0 0 1 0 2 bbbbbbbbbbbbbbbb
05 1 3 2 0 0000052 ffffffffffffffff cccccccccccccccc 1 0 0 cccccccccccccccc
05 0 2 1 3 0000052 0 0 1 0 3 cccccccccccccccc
06 2 0 0 1 0000010 ffffffffffffffff ffffffffffffffff 1 0 1 11bb11ddee110011
06 3 1 3 2 0000020 ffffffffffffffff ffffffffffffffff 1 0 2 2222222299999999
06 0 0 0 0 0000010 0 0 1 0 0 11bb11ddee110011
06 0 0 0 0 0000020 0 0 1 0 0 2222222299999999

// File: filelist.f
+incdir+hdl
hdl/l2_pkg.sv
hdl/l1d_tag_directory.sv
hdl/sync_reservation.sv
hdl/line_store.sv
hdl/response_pipe.sv
hdl/l2_cache_top.sv
test/tb_l2_cache.sv

// File: test/tb_l2_cache.sv
`timescale 1ns/10ps

module tb_l2_cache;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int FIELDS = 12;
	localparam int MAX_VECTORS = 64;
	localparam int MAX_TESTS = 16;
	localparam int BURST_TEST = 5;

	logic              clk;
	logic              rst_n_i;
	logic              pci_valid_i;
	l2_pkg::pci_req_t  pci_req_i;
	logic              pci_ack_o;
	logic              cpi_valid_o;
	l2_pkg::cpi_resp_t cpi_resp_o;

	// One hex word per field, twelve fields per request
	logic [511:0] vec_mem [FIELDS*MAX_VECTORS];
	int           pending_q [$];
	integer       seed;
	int           vec_count;
	int           error_count;
	int           test_errors [MAX_TESTS];
	int           test_left [MAX_TESTS];
	int           tests_done;
	int           tests_failed;
	logic         loaded;
	logic         issued_d1;
	logic         issued_d2;

	l2_cache_top dut0
	(
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.pci_valid_i (pci_valid_i),
		.pci_req_i   (pci_req_i),
		.pci_ack_o   (pci_ack_o),
		.cpi_valid_o (cpi_valid_o),
		.cpi_resp_o  (cpi_resp_o)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic note_error(int t);
		error_count++;
		if (t >= 0 && t < MAX_TESTS)
			test_errors[t]++;
	endtask

	task automatic compare_field(string name, logic [511:0] got, logic [511:0] want, int t);
		if (got !== want)
		begin
			$display("ERR test %0d %s: got %0h expected %0h", t, name, got, want);
			note_error(t);
		end
	endtask

	task automatic compare_response(int v, int t);
		int              b;
		logic            is_store;
		l2_pkg::cpi_op_t want_op;
		b = v * FIELDS;
		is_store = vec_mem[b+1][2:0] == l2_pkg::PCI_STORE
			|| vec_mem[b+1][2:0] == l2_pkg::PCI_STORE_SYNC;
		want_op = is_store ? l2_pkg::CPI_STORE : l2_pkg::CPI_LOAD;
		compare_field("cpi_resp_o.status", cpi_resp_o.status, vec_mem[b+8][0], t);
		compare_field("cpi_resp_o.unit", cpi_resp_o.unit, vec_mem[b+2][1:0], t);
		compare_field("cpi_resp_o.strand", cpi_resp_o.strand, vec_mem[b+3][1:0], t);
		compare_field("cpi_resp_o.op", cpi_resp_o.op, want_op, t);
		compare_field("cpi_resp_o.update", cpi_resp_o.update, vec_mem[b+9][0], t);
		compare_field("cpi_resp_o.way", cpi_resp_o.way, vec_mem[b+10][1:0], t);
		compare_field("cpi_resp_o.data", cpi_resp_o.data, vec_mem[b+11], t);
	endtask

	task automatic issue_vector(int v);
		int b;
		b = v * FIELDS;
		// unit, strand, op, way, address, data, mask
		pci_req_i = {vec_mem[b+2][1:0], vec_mem[b+3][1:0], vec_mem[b+1][2:0],
			vec_mem[b+4][1:0], vec_mem[b+5][25:0], vec_mem[b+7],
			vec_mem[b+6][63:0]};
		pci_valid_i = 1'b1;
		pending_q.push_back(v);
		issued_d1 = 1'b1;
	endtask

	task automatic finish_request(int t);
		test_left[t]--;
		if (test_left[t] == 0)
		begin
			tests_done++;
			if (test_errors[t] == 0)
				$display("Test %0d: pass", t);
			else
			begin
				tests_failed++;
				$display("Test %0d: FAIL with %0d errors", t, test_errors[t]);
			end
		end
	endtask

	// Runs on the falling edge, before the next request is driven
	task automatic check_outputs();
		int v;
		int t;
		if (pci_ack_o !== issued_d1)
		begin
			$display("Ack missing or unexpected, request one cycle earlier was %b", issued_d1);
			note_error(-1);
		end
		if (cpi_valid_o !== 1'b0 && pending_q.size() == 0)
		begin
			$display("Response seen with no request outstanding");
			note_error(-1);
		end
		else if (cpi_valid_o !== 1'b0 || (issued_d2 && pending_q.size() != 0))
		begin
			v = pending_q.pop_front();
			t = vec_mem[v*FIELDS][7:0];
			if (!issued_d2 || cpi_valid_o !== 1'b1)
			begin
				$display("Test %0d: cpi_valid_o not high exactly two cycles after the request",
					t);
				note_error(t);
			end
			else
				compare_response(v, t);
			finish_request(t);
		end
		issued_d2 = issued_d1;
		issued_d1 = 1'b0;
	endtask

	initial
	begin
		int gap;
		int next_vec;
		seed = 32'h13b4062e;
		clk = 1'b0;
		rst_n_i = 1'b0;
		pci_valid_i = 1'b0;
		pci_req_i = '0;
		loaded = 1'b0;
		issued_d1 = 1'b0;
		issued_d2 = 1'b0;
		// Words past the end of the file keep bit 511 set
		for (int i = 0; i < FIELDS*MAX_VECTORS; i++)
			vec_mem[i] = {1'b1, 511'(i)};
		$readmemh("test/l2_vectors.txt", vec_mem);
		while (vec_count < MAX_VECTORS && vec_mem[vec_count*FIELDS][511] === 1'b0
			&& vec_mem[vec_count*FIELDS] < MAX_TESTS)
		begin
			test_left[vec_mem[vec_count*FIELDS][7:0]]++;
			vec_count++;
		end
		if (vec_count == 0 || (vec_count < MAX_VECTORS
			&& vec_mem[vec_count*FIELDS][511] === 1'b0))
		begin
			$display("Vector file is empty or holds a test number out of range");
			note_error(-1);
		end
		loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		gap = 0;
		next_vec = 0;
		while (next_vec < vec_count || issued_d1 || issued_d2)
		begin
			@(negedge clk);
			check_outputs();
			if (next_vec < vec_count && gap == 0)
			begin
				issue_vector(next_vec);
				next_vec++;
				// Burst requests follow each other with no idle cycle
				if (next_vec < vec_count && vec_mem[next_vec*FIELDS] == BURST_TEST)
					gap = 0;
				else
					gap = $unsigned($random(seed)) % 3;
			end
			else
			begin
				pci_valid_i = 1'b0;
				if (gap > 0)
					gap--;
			end
		end
		@(negedge clk);
		check_outputs();
		if (pending_q.size() != 0)
		begin
			$display("%0d requests never got a response", pending_q.size());
			note_error(-1);
		end
		$display("Summary: %0d tests finished, %0d failed, %0d errors",
			tests_done, tests_failed, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin
		wait (loaded === 1'b1);
		#((vec_count * 4 + 50) * CLK_PERIOD);
		$display("Watchdog: run went past %0d clock periods", vec_count * 4 + 50);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: hdl/l2_cache_top.sv
`timescale 1ns/10ps

module l2_cache_top
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              pci_valid_i,
	input  l2_pkg::pci_req_t  pci_req_i,
	output logic              pci_ack_o,
	output logic              cpi_valid_o,
	output l2_pkg::cpi_resp_t cpi_resp_o
);

	logic [511:0] old_line;
	logic [511:0] merged_line;
	logic         sync_ok;
	logic         l1_hit;
	logic [1:0]   l1_hit_way;
	logic         dir_update;

	// Unit 1 is the data cache; its fills land in the requested way
	assign dir_update = pci_valid_i && pci_req_i.unit == 2'd1
		&& (pci_req_i.op == l2_pkg::PCI_LOAD || pci_req_i.op == l2_pkg::PCI_LOAD_SYNC);

	l1d_tag_directory u_l1d_tag_directory
	(
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.lookup_i     (pci_valid_i),
		.address_i    (pci_req_i.address),
		.update_i     (dir_update),
		.update_way_i (pci_req_i.way),
		.hit_o        (l1_hit),
		.hit_way_o    (l1_hit_way)
	);

	sync_reservation u_sync_reservation
	(
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.valid_i   (pci_valid_i),
		.req_i     (pci_req_i),
		.sync_ok_o (sync_ok)
	);

	line_store u_line_store
	(
		.clk           (clk),
		.valid_i       (pci_valid_i),
		.req_i         (pci_req_i),
		.sync_ok_i     (sync_ok),
		.old_line_o    (old_line),
		.merged_line_o (merged_line)
	);

	response_pipe u_response_pipe
	(
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.valid_i       (pci_valid_i),
		.req_i         (pci_req_i),
		.old_line_i    (old_line),
		.merged_line_i (merged_line),
		.sync_ok_i     (sync_ok),
		.l1_hit_i      (l1_hit),
		.l1_hit_way_i  (l1_hit_way),
		.ack_o         (pci_ack_o),
		.resp_valid_o  (cpi_valid_o),
		.resp_o        (cpi_resp_o)
	);

endmodule

// File: hdl/response_pipe.sv
`timescale 1ns/10ps

module response_pipe
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              valid_i,
	input  l2_pkg::pci_req_t  req_i,
	input  logic [511:0]      old_line_i,
	input  logic [511:0]      merged_line_i,
	input  logic              sync_ok_i,
	input  logic              l1_hit_i,
	input  logic [1:0]        l1_hit_way_i,
	output logic              ack_o,
	output logic              resp_valid_o,
	output l2_pkg::cpi_resp_t resp_o
);

	l2_pkg::resp_stage_t s1_next;
	l2_pkg::resp_stage_t s1_q;
	logic                s1_is_store;
	logic                ack_q;
	logic                resp_valid_q;
	logic                status_q;
	logic                update_q;
	logic [1:0]          unit_q;
	logic [1:0]          strand_q;
	l2_pkg::cpi_op_t     op_q;
	logic [1:0]          way_q;
	logic [511:0]        data_q;

	// Stage one record from the incoming request
	always_comb
	begin
		s1_next.valid = valid_i;
		s1_next.unit = req_i.unit;
		s1_next.strand = req_i.strand;
		s1_next.way = req_i.way;
		case (req_i.op)
			l2_pkg::PCI_STORE, l2_pkg::PCI_STORE_SYNC:
			begin
				s1_next.op = l2_pkg::CPI_STORE;
				s1_next.data = merged_line_i;
			end
			default:
			begin
				// Flush and invalidate come back as plain loads
				s1_next.op = l2_pkg::CPI_LOAD;
				s1_next.data = old_line_i;
			end
		endcase
		s1_next.status = (req_i.op == l2_pkg::PCI_STORE_SYNC) ? sync_ok_i : 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			s1_q <= '0;
		else
			s1_q <= s1_next;
	end

	assign s1_is_store = s1_q.op == l2_pkg::CPI_STORE;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ack_q <= 1'b0;
			resp_valid_q <= 1'b0;
			status_q <= 1'b0;
			update_q <= 1'b0;
		end
		else
		begin
			ack_q <= valid_i;
			resp_valid_q <= s1_q.valid;
			if (s1_q.valid)
			begin
				status_q <= s1_q.status;
				update_q <= s1_is_store && l1_hit_i;
			end
		end
	end

	// Directory result lines up with stage one here
	always_ff @(posedge clk)
	begin
		if (s1_q.valid)
		begin
			unit_q <= s1_q.unit;
			strand_q <= s1_q.strand;
			op_q <= s1_q.op;
			way_q <= s1_is_store ? l1_hit_way_i : s1_q.way;
			data_q <= s1_q.data;
		end
	end

	assign ack_o = ack_q;
	assign resp_valid_o = resp_valid_q;

	always_comb
	begin
		resp_o.status = status_q;
		resp_o.unit = unit_q;
		resp_o.strand = strand_q;
		resp_o.op = op_q;
		resp_o.update = update_q;
		resp_o.way = way_q;
		resp_o.data = data_q;
	end

endmodule

// File: hdl/line_store.sv
`timescale 1ns/10ps
`include "l2_config.svh"

module line_store
(
	input  logic             clk,
	input  logic             valid_i,
	input  l2_pkg::pci_req_t req_i,
	input  logic             sync_ok_i,
	output logic [511:0]     old_line_o,
	output logic [511:0]     merged_line_o
);

	localparam int unsigned IDX_BITS = $clog2(`L2_LINE_COUNT);

	logic [511:0]         lines [`L2_LINE_COUNT];
	logic [IDX_BITS-1:0]  line_idx;
	logic [511:0]         old_line;
	logic [511:0]         merged_line;
	logic                 write_en;

	assign line_idx = req_i.address[IDX_BITS-1:0];
	assign old_line = lines[line_idx];

	// Byte b of the line comes from the request when mask bit b is set
	genvar b;
	generate
		for (b = 0; b < 64; b++)
		begin : g_byte
			assign merged_line[b*8 +: 8] = req_i.mask[b] ? req_i.data[b*8 +: 8]
				: old_line[b*8 +: 8];
		end
	endgenerate

	// Failed store-sync leaves the line untouched
	always_comb
	begin
		write_en = 1'b0;
		if (valid_i)
		begin
			case (req_i.op)
				l2_pkg::PCI_STORE:
					write_en = 1'b1;
				l2_pkg::PCI_STORE_SYNC:
					write_en = sync_ok_i;
				default:
					write_en = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (write_en)
			lines[line_idx] <= merged_line;
	end

	assign old_line_o = old_line;
	assign merged_line_o = merged_line;

endmodule

// File: hdl/sync_reservation.sv
`timescale 1ns/10ps
`include "l2_config.svh"

module sync_reservation
(
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             valid_i,
	input  l2_pkg::pci_req_t req_i,
	output logic             sync_ok_o
);

	logic [`L2_SET_BITS+`L2_TAG_BITS-1:0] resv_addr [`L2_STRANDS];
	logic [`L2_STRANDS-1:0]               resv_valid;
	logic                                 is_store;
	logic                                 is_load_sync;

	assign is_store = req_i.op == l2_pkg::PCI_STORE || req_i.op == l2_pkg::PCI_STORE_SYNC;
	assign is_load_sync = req_i.op == l2_pkg::PCI_LOAD_SYNC;

	// Verdict for the requesting strand against the current address
	assign sync_ok_o = resv_valid[req_i.strand] && resv_addr[req_i.strand] == req_i.address;

	always_ff @(posedge clk)
	begin
		if (valid_i && is_load_sync)
			resv_addr[req_i.strand] <= req_i.address;
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			resv_valid <= '0;
		else if (valid_i)
		begin
			if (is_store)
			begin
				// Any store to the line breaks every strand's reservation on it
				for (int s = 0; s < `L2_STRANDS; s++)
				begin
					if (resv_addr[s] == req_i.address)
						resv_valid[s] <= 1'b0;
				end
			end
			else if (is_load_sync)
				resv_valid[req_i.strand] <= 1'b1;
		end
	end

endmodule

// File: hdl/l1d_tag_directory.sv
`timescale 1ns/10ps
`include "l2_config.svh"

module l1d_tag_directory
(
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        lookup_i,
	input  logic [25:0] address_i,
	input  logic        update_i,
	input  logic [1:0]  update_way_i,
	output logic        hit_o,
	output logic [1:0]  hit_way_o
);

	logic [`L2_SET_BITS-1:0]           set_idx;
	logic [`L2_TAG_BITS-1:0]           tag;
	logic [`L2_TAG_BITS-1:0]           tag_mem [`L2_WAYS][`L2_SETS];
	logic [`L2_WAYS-1:0][`L2_SETS-1:0] valid_q;
	logic                              hit;
	logic [1:0]                        hit_way;
	logic                              hit_q;
	logic [1:0]                        hit_way_q;

	assign set_idx = address_i[`L2_SET_BITS-1:0];
	assign tag = address_i[`L2_SET_BITS +: `L2_TAG_BITS];

	// Compare every way of the addressed set
	always_comb
	begin
		hit = 1'b0;
		hit_way = 2'd0;
		for (int w = 0; w < `L2_WAYS; w++)
		begin
			if (valid_q[w][set_idx] && tag_mem[w][set_idx] == tag)
			begin
				hit = 1'b1;
				hit_way = 2'(w);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (update_i)
			tag_mem[update_way_i][set_idx] <= tag;
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			valid_q <= '0;
		else if (update_i)
			valid_q[update_way_i][set_idx] <= 1'b1;
	end

	// Lookup sees the contents before an update on the same edge
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			hit_q <= 1'b0;
		else
			hit_q <= lookup_i && hit;
	end

	always_ff @(posedge clk)
	begin
		if (lookup_i)
			hit_way_q <= hit_way;
	end

	assign hit_o = hit_q;
	assign hit_way_o = hit_way_q;

endmodule

// File: hdl/l2_pkg.sv
`include "l2_config.svh"

package l2_pkg;

	// Request operations on the processor to cache port
	typedef enum logic [2:0]
	{
		PCI_LOAD       = 3'd0,
		PCI_STORE      = 3'd1,
		PCI_FLUSH      = 3'd2,
		PCI_INVALIDATE = 3'd3,
		PCI_LOAD_SYNC  = 3'd4,
		PCI_STORE_SYNC = 3'd5
	} pci_op_t;

	// Response operations; write-validate is reserved
	typedef enum logic [1:0]
	{
		CPI_LOAD           = 2'd0,
		CPI_STORE          = 2'd1,
		CPI_WRITE_VALIDATE = 2'd2
	} cpi_op_t;

	typedef struct packed
	{
		logic [1:0]                               unit;
		logic [1:0]                               strand;
		pci_op_t                                  op;
		logic [1:0]                               way;
		logic [`L2_SET_BITS+`L2_TAG_BITS-1:0]     address;
		logic [511:0]                             data;
		logic [63:0]                              mask;
	} pci_req_t;

	typedef struct packed
	{
		logic         status;
		logic [1:0]   unit;
		logic [1:0]   strand;
		cpi_op_t      op;
		logic         update;
		logic [1:0]   way;
		logic [511:0] data;
	} cpi_resp_t;

	// First response stage, before the directory result is known
	typedef struct packed
	{
		logic         valid;
		logic         status;
		logic [1:0]   unit;
		logic [1:0]   strand;
		cpi_op_t      op;
		logic [1:0]   way;
		logic [511:0] data;
	} resp_stage_t;

endpackage

// File: hdl/l2_config.svh
`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

// Flat line array, indexed by the low bits of the line address
`define L2_LINE_COUNT 256

// Hardware strands, one reservation each
`define L2_STRANDS 4

// Shape of the L1 data cache mirrored by the tag directory
`define L2_WAYS 4
`define L2_SETS 32

// Split of the 26-bit line address as seen by the L1
`define L2_SET_BITS 5
`define L2_TAG_BITS 21

`endif
